//--- src.f
+incdir+verification
common/arcade_pkg.sv
common/player_ctrl_if.sv
design/key_decoder/ps2_key_decoder.sv
design/joystick/joystick_debounce.sv
design/control_merge.sv
design/sigma_delta_dac.sv
design/arcade_io_top.sv
verification/tb_arcade_io.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and decides the result from the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing -j 0 --top-module tb_arcade_io -f src.f -o tb_arcade_io \
	|| { echo "build failed"; exit 1; }

./obj_dir/tb_arcade_io > "$log" 2>&1
cat "$log"

grep -q "Done: no errors" "$log" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- verification/tb_model.svh
// reference model included by the testbench, expected active-low controls and converter pulse counts
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// slot of a scan code in the held-key vector, -1 when unmapped
function automatic int key_index(input logic [key_code_w-1:0] code);
	case (code)
		sc_up:                  return 0;
		sc_down:                return 1;
		sc_left:                return 2;
		sc_right:               return 3;
		sc_fire1_a, sc_fire1_b: return 4; // ctrl or alt
		sc_coin:                return 5;
		sc_start1:              return 6;
		sc_start2:              return 7;
		sc_fire2:               return 8; // space
		default:                return -1;
	endcase
endfunction

// bit 14 is up1_n down to bit 0 game_reset_n
function automatic logic [14:0] expected_controls(input logic [8:0] keys,
	input logic [joy_w-1:0] j1, input logic [joy_w-1:0] j2,
	input logic [status_w-1:0] st, input logic [1:0] btn);
	logic [14:0] act; // active high
	act[14] = keys[0] | j1[joy_up];
	act[13] = keys[1] | j1[joy_down];
	act[12] = keys[2] | j1[joy_left];
	act[11] = keys[3] | j1[joy_right];
	act[10] = keys[4] | j1[joy_fire];
	act[9]  = j2[joy_up];             // player 2 directions from stick only
	act[8]  = j2[joy_down];
	act[7]  = j2[joy_left];
	act[6]  = j2[joy_right];
	act[5]  = j2[joy_fire] | keys[8];
	act[4]  = keys[5];
	act[3]  = keys[6];
	act[2]  = keys[7];
	act[1]  = st[st_test_bit];
	act[0]  = st[st_reset_bit] | st[st_menu_reset_bit] | btn[btn_reset_bit];
	return ~act;
endfunction

// ones in any window of 2**audio_width cycles for a held sample
function automatic int expected_ones(input logic [audio_width-1:0] s);
	return int'(s);
endfunction

`endif

//--- verification/tb_arcade_io.sv
// testbench for arcade_io_top, drives keys, joysticks, status and samples and checks a reference model
`timescale 1ns/1ps

module tb_arcade_io
	import arcade_pkg::*;
();

	localparam int clk_period      = 40;
	localparam int audio_width     = 7;
	localparam int debounce_cycles = 4;
	localparam int n_key           = 300;
	localparam int n_joy           = 40;
	localparam int n_glitch        = 20;
	localparam int n_audio         = 10;
	localparam int n_fixed         = 20;
	localparam int max_wait        = (1 << audio_width) + debounce_cycles + 8;
	localparam int watchdog_cycles = (n_key + n_joy + 2 * n_glitch + n_audio + n_fixed) * max_wait;

	`include "tb_model.svh"

	logic                   clk_24;
	logic                   arst_n;
	logic [key_event_w-1:0] key_event;
	logic [joy_w-1:0]       joystick_0;
	logic [joy_w-1:0]       joystick_1;
	logic [status_w-1:0]    status;
	logic [1:0]             buttons;
	logic [audio_width-1:0] sample;
	logic                   up1_n;
	logic                   down1_n;
	logic                   left1_n;
	logic                   right1_n;
	logic                   fire1_n;
	logic                   up2_n;
	logic                   down2_n;
	logic                   left2_n;
	logic                   right2_n;
	logic                   fire2_n;
	logic                   coin1_n;
	logic                   start1_n;
	logic                   start2_n;
	logic                   test_n;
	logic                   game_reset_n;
	logic                   audio_l;
	logic                   audio_r;

	logic [8:0]       keys_m; // held keys, slots as in key_index
	logic [joy_w-1:0] joy1_m;
	logic [joy_w-1:0] joy2_m;
	logic [14:0]      exp_ctrl;
	logic [14:0]      act_ctrl;
	int               errors;
	event             check_ev;

	string ctrl_names [15] = '{"up1_n", "down1_n", "left1_n", "right1_n", "fire1_n",
		"up2_n", "down2_n", "left2_n", "right2_n", "fire2_n",
		"coin1_n", "start1_n", "start2_n", "test_n", "game_reset_n"};
	logic [key_code_w-1:0] mapped_codes [10] = '{sc_up, sc_down, sc_left, sc_right, sc_coin,
		sc_start1, sc_start2, sc_fire1_a, sc_fire1_b, sc_fire2};

	assign act_ctrl = {up1_n, down1_n, left1_n, right1_n, fire1_n, up2_n, down2_n, left2_n,
		right2_n, fire2_n, coin1_n, start1_n, start2_n, test_n, game_reset_n};

	arcade_io_top #(
		.AUDIO_WIDTH     (audio_width),
		.DEBOUNCE_CYCLES (debounce_cycles)
	) UUT (
		.clk_24       (clk_24),
		.arst_n       (arst_n),
		.key_event    (key_event),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.status       (status),
		.buttons      (buttons),
		.sample       (sample),
		.up1_n        (up1_n),
		.down1_n      (down1_n),
		.left1_n      (left1_n),
		.right1_n     (right1_n),
		.fire1_n      (fire1_n),
		.up2_n        (up2_n),
		.down2_n      (down2_n),
		.left2_n      (left2_n),
		.right2_n     (right2_n),
		.fire2_n      (fire2_n),
		.coin1_n      (coin1_n),
		.start1_n     (start1_n),
		.start2_n     (start2_n),
		.test_n       (test_n),
		.game_reset_n (game_reset_n),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	initial begin
		clk_24 = 1'b0;
		forever #(clk_period / 2) clk_24 = ~clk_24;
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
			$display("Done: errors found");
			$fatal(1, "run stopped at first mismatch");
		end
	endtask

	// compares every control output when the stimulus asks for it
	initial begin
		forever begin
			@(check_ev);
			for (int i = 0; i < 15; i++) begin
				compare_value(ctrl_names[i], 32'(exp_ctrl[14 - i]), 32'(act_ctrl[14 - i]));
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk_24);
		$display("timeout: tests did not finish within %0d clock cycles", watchdog_cycles);
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_24);
	endtask

	task automatic check_controls();
		exp_ctrl = expected_controls(keys_m, joy1_m, joy2_m, status, buttons);
		-> check_ev;
	endtask

	task automatic send_key(input logic [key_code_w-1:0] code, input logic pressed,
		input logic flip);
		int slot;
		@(negedge clk_24);
		key_event[key_toggle_bit]             = key_event[key_toggle_bit] ^ flip;
		key_event[key_pressed_bit]            = pressed;
		key_event[key_code_lsb + key_code_w]  = 1'($urandom); // extended flag, ignored
		key_event[key_code_lsb +: key_code_w] = code;
		slot = key_index(code);
		if (flip && slot >= 0)
			keys_m[slot] = pressed;
		wait_cycles(2);
		check_controls();
	endtask

	task automatic hold_joystick(input logic [joy_w-1:0] j1, input logic [joy_w-1:0] j2);
		@(negedge clk_24);
		joystick_0 = j1;
		joystick_1 = j2;
		joy1_m     = j1;
		joy2_m     = j2;
		wait_cycles(debounce_cycles + 4);
		check_controls();
	endtask

	task automatic glitch_joystick(input logic [joy_w-1:0] m1, input logic [joy_w-1:0] m2);
		@(negedge clk_24);
		joystick_0 = joy1_m ^ m1;
		joystick_1 = joy2_m ^ m2;
		for (int i = 0; i < debounce_cycles - 1; i++) begin // one sample short of acceptance
			wait_cycles(1);
			check_controls();
		end
		joystick_0 = joy1_m;
		joystick_1 = joy2_m;
		for (int i = 0; i < debounce_cycles + 4; i++) begin
			wait_cycles(1);
			check_controls(); // outputs never move
		end
	endtask

	task automatic set_sources(input logic [status_w-1:0] st, input logic [1:0] btn);
		@(negedge clk_24);
		status  = st;
		buttons = btn;
		wait_cycles(1);
		check_controls();
	endtask

	task automatic measure_audio(input logic [audio_width-1:0] s);
		int ones;
		ones = 0;
		@(negedge clk_24);
		sample = s;
		wait_cycles(1);
		for (int i = 0; i < (1 << audio_width); i++) begin
			if (audio_l)
				ones++;
			compare_value("audio_r", 32'(audio_l), 32'(audio_r));
			@(negedge clk_24);
		end
		compare_value("audio_l ones", 32'(expected_ones(s)), 32'(ones));
	endtask

	initial begin
		logic [key_code_w-1:0] code;
		int pick;
		void'($urandom(32'h9206fd76));
		arst_n     = 1'b0;
		key_event  = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		status     = '0;
		buttons    = '0;
		sample     = '0;
		keys_m     = '0;
		joy1_m     = '0;
		joy2_m     = '0;
		errors     = 0;

		repeat (2) @(negedge clk_24);
		exp_ctrl = 15'h7ffe; // controls idle, core held in reset
		-> check_ev;
		compare_value("audio_l", 32'd0, 32'(audio_l));
		@(negedge clk_24);
		arst_n = 1'b1;
		wait_cycles(1);
		check_controls();

		for (int i = 0; i < n_key; i++) begin
			pick = int'($urandom % 4);
			if (pick == 0)
				code = key_code_w'($urandom);
			else
				code = mapped_codes[int'($urandom % 10)];
			send_key(code, 1'($urandom), ($urandom % 8) != 0);
		end
		send_key(sc_fire1_a, 1'b1, 1'b1);
		send_key(sc_fire1_b, 1'b0, 1'b1); // alt releases what ctrl pressed
		send_key(sc_fire1_b, 1'b1, 1'b1);
		send_key(sc_fire1_a, 1'b0, 1'b0); // no toggle flip, no event

		for (int i = 0; i < n_joy; i++)
			hold_joystick(joy_w'($urandom), joy_w'($urandom));
		for (int i = 0; i < n_glitch; i++)
			glitch_joystick(joy_w'($urandom) | joy_w'(1 << (i % 5)), joy_w'($urandom));

		hold_joystick('0, '0);
		send_key(sc_up, 1'b1, 1'b1);
		hold_joystick(joy_w'(1 << joy_up), '0);
		send_key(sc_up, 1'b0, 1'b1);
		compare_value("up1_n", 32'd0, 32'(up1_n)); // stick still holds up
		hold_joystick('0, '0);
		compare_value("up1_n", 32'd1, 32'(up1_n));
		send_key(sc_left, 1'b1, 1'b1);
		compare_value("left2_n", 32'd1, 32'(left2_n));
		send_key(sc_left, 1'b0, 1'b1);

		set_sources(status_w'(1 << st_reset_bit), 2'b00);
		set_sources('0, 2'b00);
		set_sources(status_w'(1 << st_menu_reset_bit), 2'b00);
		set_sources('0, 2'b00);
		set_sources('0, 2'b10);
		set_sources('0, 2'b01);
		set_sources(status_w'(1 << st_test_bit), 2'b00);
		set_sources('0, 2'b00);

		for (int i = 0; i < n_audio; i++) begin
			if (i == 0)
				measure_audio('0);
			else if (i == 1)
				measure_audio('1);
			else
				measure_audio(audio_width'($urandom));
		end

		@(negedge clk_24);
		if (errors == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "checks failed");
		end
	end

endmodule

//--- design/arcade_io_top.sv
// top of the control and sound front end, wires decoders, merger and converter to plain ports
`timescale 1ns/1ps

module arcade_io_top
	import arcade_pkg::*;
#(
	parameter int AUDIO_WIDTH     = 7,
	parameter int DEBOUNCE_CYCLES = 4
) (
	input  logic                   clk_24,
	input  logic                   arst_n,
	input  logic [key_event_w-1:0] key_event,
	input  logic [joy_w-1:0]       joystick_0,
	input  logic [joy_w-1:0]       joystick_1,
	input  logic [status_w-1:0]    status,
	input  logic [1:0]             buttons,
	input  logic [AUDIO_WIDTH-1:0] sample,
	output logic                   up1_n,
	output logic                   down1_n,
	output logic                   left1_n,
	output logic                   right1_n,
	output logic                   fire1_n,
	output logic                   up2_n,
	output logic                   down2_n,
	output logic                   left2_n,
	output logic                   right2_n,
	output logic                   fire2_n,
	output logic                   coin1_n,
	output logic                   start1_n,
	output logic                   start2_n,
	output logic                   test_n,
	output logic                   game_reset_n,
	output logic                   audio_l,
	output logic                   audio_r
);

	player_ctrl_if kbd ();
	player_ctrl_if joy1 ();
	player_ctrl_if joy2 ();

	logic kbd_fire2;
	logic audio_bit;

	ps2_key_decoder u_key_decoder (
		.clk_24    (clk_24),
		.arst_n    (arst_n),
		.key_event (key_event),
		.kbd1      (kbd.source),
		.fire2     (kbd_fire2)
	);

	joystick_debounce #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) u_joy1_debounce (
		.clk_24 (clk_24),
		.arst_n (arst_n),
		.joy    (joystick_0),
		.ctrl   (joy1.source)
	);

	joystick_debounce #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) u_joy2_debounce (
		.clk_24 (clk_24),
		.arst_n (arst_n),
		.joy    (joystick_1),
		.ctrl   (joy2.source)
	);

	control_merge u_control_merge (
		.clk_24       (clk_24),
		.arst_n       (arst_n),
		.kbd          (kbd.sink),
		.joy1         (joy1.sink),
		.joy2         (joy2.sink),
		.kbd_fire2    (kbd_fire2),
		.status       (status),
		.buttons      (buttons),
		.up1_n        (up1_n),
		.down1_n      (down1_n),
		.left1_n      (left1_n),
		.right1_n     (right1_n),
		.fire1_n      (fire1_n),
		.up2_n        (up2_n),
		.down2_n      (down2_n),
		.left2_n      (left2_n),
		.right2_n     (right2_n),
		.fire2_n      (fire2_n),
		.coin1_n      (coin1_n),
		.start1_n     (start1_n),
		.start2_n     (start2_n),
		.test_n       (test_n),
		.game_reset_n (game_reset_n)
	);

	sigma_delta_dac #(
		.AUDIO_WIDTH (AUDIO_WIDTH)
	) u_dac (
		.clk_24    (clk_24),
		.arst_n    (arst_n),
		.sample    (sample),
		.audio_out (audio_bit)
	);

	assign audio_l = audio_bit; // mono, same bit on both channels
	assign audio_r = audio_bit;

endmodule

//--- design/sigma_delta_dac.sv
// first-order sigma-delta converter, one output bit per clock from the sound sample
`timescale 1ns/1ps

module sigma_delta_dac #(
	parameter int AUDIO_WIDTH = 7
) (
	input  logic                   clk_24,
	input  logic                   arst_n,
	input  logic [AUDIO_WIDTH-1:0] sample,
	output logic                   audio_out
);

	logic [AUDIO_WIDTH-1:0] acc_q;
	logic [AUDIO_WIDTH-1:0] acc_sum;
	logic                   carry;

	// carry out of the accumulator is the pulse density
	assign {carry, acc_sum} = {1'b0, acc_q} + {1'b0, sample};

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			acc_q     <= '0;
			audio_out <= 1'b0;
		end else begin
			acc_q     <= acc_sum;
			audio_out <= carry;
		end
	end

endmodule

//--- design/control_merge.sv
// merges keyboard and joystick buttons into registered active-low game inputs and the game reset
`timescale 1ns/1ps

module control_merge
	import arcade_pkg::*;
(
	input  logic                clk_24,
	input  logic                arst_n,
	player_ctrl_if.sink         kbd,
	player_ctrl_if.sink         joy1,
	player_ctrl_if.sink         joy2,
	input  logic                kbd_fire2,
	input  logic [status_w-1:0] status,
	input  logic [1:0]          buttons,
	output logic                up1_n,
	output logic                down1_n,
	output logic                left1_n,
	output logic                right1_n,
	output logic                fire1_n,
	output logic                up2_n,
	output logic                down2_n,
	output logic                left2_n,
	output logic                right2_n,
	output logic                fire2_n,
	output logic                coin1_n,
	output logic                start1_n,
	output logic                start2_n,
	output logic                test_n,
	output logic                game_reset_n
);

	logic reset_req;

	assign reset_req = status[st_reset_bit] | status[st_menu_reset_bit] | buttons[btn_reset_bit];

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			up1_n        <= 1'b1;
			down1_n      <= 1'b1;
			left1_n      <= 1'b1;
			right1_n     <= 1'b1;
			fire1_n      <= 1'b1;
			up2_n        <= 1'b1;
			down2_n      <= 1'b1;
			left2_n      <= 1'b1;
			right2_n     <= 1'b1;
			fire2_n      <= 1'b1;
			coin1_n      <= 1'b1;
			start1_n     <= 1'b1;
			start2_n     <= 1'b1;
			test_n       <= 1'b1;
			game_reset_n <= 1'b0; // core held in reset
		end else begin
			up1_n        <= ~(kbd.up | joy1.up);
			down1_n      <= ~(kbd.down | joy1.down);
			left1_n      <= ~(kbd.left | joy1.left);
			right1_n     <= ~(kbd.right | joy1.right);
			fire1_n      <= ~(kbd.fire | joy1.fire);
			up2_n        <= ~joy2.up;             // player 2 directions from stick only
			down2_n      <= ~joy2.down;
			left2_n      <= ~joy2.left;
			right2_n     <= ~joy2.right;
			fire2_n      <= ~(joy2.fire | kbd_fire2); // space also fires player 2
			coin1_n      <= ~kbd.coin;
			start1_n     <= ~kbd.start1;
			start2_n     <= ~kbd.start2;
			test_n       <= ~status[st_test_bit];
			game_reset_n <= ~reset_req;
		end
	end

endmodule

//--- design/joystick/joystick_debounce.sv
// debounces the direction and fire bits of one joystick word, instantiated once per player
`timescale 1ns/1ps

module joystick_debounce
	import arcade_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = 4
) (
	input  logic             clk_24,
	input  logic             arst_n,
	input  logic [joy_w-1:0] joy,
	player_ctrl_if.source    ctrl
);

	localparam int NBITS = joy_fire - joy_right + 1; // right, left, down, up, fire
	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

	logic [NBITS-1:0] raw_q;          // sampled joystick bits
	logic [NBITS-1:0] stable_q;       // accepted values
	logic [CNT_W-1:0] cnt_q [NBITS];

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			raw_q    <= '0;
			stable_q <= '0;
			for (int i = 0; i < NBITS; i++) begin
				cnt_q[i] <= '0;
			end
		end else begin
			raw_q <= joy[joy_fire:joy_right];
			for (int i = 0; i < NBITS; i++) begin
				if (raw_q[i] == stable_q[i]) begin
					cnt_q[i] <= '0; // back to accepted, restart
				end else if (cnt_q[i] == CNT_LAST) begin
					stable_q[i] <= raw_q[i];
					cnt_q[i]    <= '0;
				end else begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
				end
			end
		end
	end

	assign ctrl.right  = stable_q[joy_right - joy_right];
	assign ctrl.left   = stable_q[joy_left - joy_right];
	assign ctrl.down   = stable_q[joy_down - joy_right];
	assign ctrl.up     = stable_q[joy_up - joy_right];
	assign ctrl.fire   = stable_q[joy_fire - joy_right];

	// no coin or start buttons on the joystick path
	assign ctrl.coin   = 1'b0;
	assign ctrl.start1 = 1'b0;
	assign ctrl.start2 = 1'b0;

endmodule

//--- design/key_decoder/ps2_key_decoder.sv
// turns toggle-flagged key events into held key states for player 1 and the space fire key
`timescale 1ns/1ps

module ps2_key_decoder
	import arcade_pkg::*;
(
	input  logic                   clk_24,
	input  logic                   arst_n,
	input  logic [key_event_w-1:0] key_event,
	player_ctrl_if.source          kbd1,
	output logic                   fire2
);

	logic                  toggle_q;
	logic                  key_new;
	logic                  pressed;
	logic [key_code_w-1:0] code;

	logic up_q;
	logic down_q;
	logic left_q;
	logic right_q;
	logic coin_q;
	logic start1_q;
	logic start2_q;
	logic fire1_q;
	logic fire2_q;

	assign key_new = key_event[key_toggle_bit] ^ toggle_q; // any flip is one event
	assign pressed = key_event[key_pressed_bit];
	assign code    = key_event[key_code_lsb +: key_code_w];

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q <= 1'b0;
			up_q     <= 1'b0;
			down_q   <= 1'b0;
			left_q   <= 1'b0;
			right_q  <= 1'b0;
			coin_q   <= 1'b0;
			start1_q <= 1'b0;
			start2_q <= 1'b0;
			fire1_q  <= 1'b0;
			fire2_q  <= 1'b0;
		end else begin
			toggle_q <= key_event[key_toggle_bit];
			if (key_new) begin
				case (code)
					sc_up:      up_q     <= pressed;
					sc_down:    down_q   <= pressed;
					sc_left:    left_q   <= pressed;
					sc_right:   right_q  <= pressed;
					sc_coin:    coin_q   <= pressed;
					sc_start1:  start1_q <= pressed;
					sc_start2:  start2_q <= pressed;
					sc_fire1_a: fire1_q  <= pressed; // ctrl and alt share fire1
					sc_fire1_b: fire1_q  <= pressed;
					sc_fire2:   fire2_q  <= pressed;
					default:    ;                    // unmapped, ignored
				endcase
			end
		end
	end

	assign kbd1.up     = up_q;
	assign kbd1.down   = down_q;
	assign kbd1.left   = left_q;
	assign kbd1.right  = right_q;
	assign kbd1.fire   = fire1_q;
	assign kbd1.coin   = coin_q;
	assign kbd1.start1 = start1_q;
	assign kbd1.start2 = start2_q;
	assign fire2       = fire2_q;

endmodule

//--- common/player_ctrl_if.sv
// one player's held button levels, driven by a keyboard decoder or joystick debouncer and read by the merger
`timescale 1ns/1ps

interface player_ctrl_if;

	logic up;
	logic down;
	logic left;
	logic right;
	logic fire;
	logic coin;
	logic start1;
	logic start2;

	modport source (
		output up,
		output down,
		output left,
		output right,
		output fire,
		output coin,
		output start1,
		output start2
	);

	modport sink (
		input up,
		input down,
		input left,
		input right,
		input fire,
		input coin,
		input start1,
		input start2
	);

endinterface

//--- common/arcade_pkg.sv
// shared field positions, scan codes and joystick bit indices for the arcade control front end
package arcade_pkg;

	// key event word from the configuration link
	localparam int unsigned key_event_w     = 11;
	localparam int unsigned key_toggle_bit  = 10; // flips once per event
	localparam int unsigned key_pressed_bit = 9;  // 1 press, 0 release
	localparam int unsigned key_code_lsb    = 0;
	localparam int unsigned key_code_w      = 8;  // bit 8 is the extended flag, unused

	// mapped scan codes
	localparam logic [key_code_w-1:0] sc_up      = 8'h75;
	localparam logic [key_code_w-1:0] sc_down    = 8'h72;
	localparam logic [key_code_w-1:0] sc_left    = 8'h6B;
	localparam logic [key_code_w-1:0] sc_right   = 8'h74;
	localparam logic [key_code_w-1:0] sc_coin    = 8'h76; // escape
	localparam logic [key_code_w-1:0] sc_start1  = 8'h05; // F1
	localparam logic [key_code_w-1:0] sc_start2  = 8'h06; // F2
	localparam logic [key_code_w-1:0] sc_fire1_a = 8'h14; // control
	localparam logic [key_code_w-1:0] sc_fire1_b = 8'h11; // alt
	localparam logic [key_code_w-1:0] sc_fire2   = 8'h29; // space

	// joystick word layout
	localparam int unsigned joy_w     = 8;
	localparam int unsigned joy_right = 0;
	localparam int unsigned joy_left  = 1;
	localparam int unsigned joy_down  = 2;
	localparam int unsigned joy_up    = 3;
	localparam int unsigned joy_fire  = 4;

	// status word and reset sources
	localparam int unsigned status_w          = 32;
	localparam int unsigned st_reset_bit      = 0;
	localparam int unsigned st_test_bit       = 1;
	localparam int unsigned st_menu_reset_bit = 6;
	localparam int unsigned btn_reset_bit     = 1;

endpackage
